/* common/eq_config.svh */
`ifndef EQ_CONFIG_SVH
`define EQ_CONFIG_SVH

// Sample and coefficient widths
`define EQ_DATA_WIDTH       16
`define EQ_COE_WIDTH        16

// Extra fraction bits kept in the training counters
`define EQ_COE_EXT          8

`define EQ_TAP_NUM          9

// Input samples between sign capture and the tap history
`define EQ_SIGN_DELAY       7

`define EQ_PERIOD_WIDTH     10
`define EQ_PERIOD_DEFAULT   4

`endif

/* common/eq_pkg.sv */
`include "eq_config.svh"

package eq_pkg;

    typedef logic signed [`EQ_DATA_WIDTH-1:0]                  sample_t;
    typedef logic signed [`EQ_COE_WIDTH-1:0]                   coe_t;
    typedef logic signed [`EQ_COE_WIDTH+`EQ_COE_EXT-1:0]       coe_full_t;
    typedef logic signed [`EQ_DATA_WIDTH+`EQ_COE_WIDTH+3:0]    acc_t;
    typedef logic        [`EQ_PERIOD_WIDTH-1:0]                period_t;
    typedef logic        [`EQ_TAP_NUM-1:0]                     tap_bits_t;
    typedef coe_t        [`EQ_TAP_NUM-1:0]                     coe_vec_t;

    // Unity gain of the centre tap, just under 0.25 of full scale
    localparam coe_full_t COE_ONE =
        coe_full_t'((1 << (`EQ_COE_WIDTH + `EQ_COE_EXT - 3)) - 1);

    // Same value with the fraction bits dropped
    localparam coe_t COE_ONE_RND = coe_t'(COE_ONE >>> `EQ_COE_EXT);

endpackage

/* logic/eq_control.sv */
`timescale 1ns/1ps
`include "eq_config.svh"

module eq_control (
    input  logic              clk,
    input  logic              sreset_eq,
    input  logic              i_preset,
    input  logic              i_teach_en,
    input  eq_pkg::period_t   i_norm_period,
    input  logic              i_sym_vld,
    output logic              o_preset,
    output logic              o_train,
    output logic              o_leak
);

    logic              preset_reg;
    logic              teach_reg;
    eq_pkg::period_t   period_reg;
    eq_pkg::period_t   period_cnt;
    logic              period_hit;

    // Control pipe registers
    always_ff @(posedge clk) begin
        if (sreset_eq) begin
            preset_reg <= 1'b1;
            teach_reg  <= 1'b0;
            period_reg <= eq_pkg::period_t'(`EQ_PERIOD_DEFAULT);
        end else begin
            preset_reg <= i_preset;
            teach_reg  <= i_teach_en;
            period_reg <= i_norm_period;
        end
    end

    // End of normalization period, counted in symbols
    assign period_hit = i_sym_vld && (period_cnt == period_reg);

    // Keeps running with teach off
    always_ff @(posedge clk) begin
        if (sreset_eq) begin
            period_cnt <= '0;
        end else if (period_hit) begin
            period_cnt <= '0;
        end else if (i_sym_vld) begin
            period_cnt <= period_cnt + 1'b1;
        end
    end

    assign o_preset = preset_reg;
    assign o_train  = i_sym_vld & teach_reg;

    // Leak step replaces the error step
    assign o_leak   = period_hit & teach_reg;

endmodule

/* logic/sign_error_gen.sv */
`timescale 1ns/1ps
`include "eq_config.svh"

module sign_error_gen (
    input  logic                clk,
    input  logic                sreset_eq,
    input  eq_pkg::sample_t     i_data_i,
    input  eq_pkg::sample_t     i_data_q,
    input  logic                i_vld,
    input  logic                i_sym_vld,
    input  logic                i_err_i,
    input  logic                i_err_q,
    output eq_pkg::tap_bits_t   o_err_i,
    output eq_pkg::tap_bits_t   o_err_q
);

    localparam int DLY = `EQ_SIGN_DELAY;

    logic [DLY-1:0]      sign_dly_i;
    logic [DLY-1:0]      sign_dly_q;
    eq_pkg::tap_bits_t   hist_i;
    eq_pkg::tap_bits_t   hist_q;
    eq_pkg::tap_bits_t   err_i;
    eq_pkg::tap_bits_t   err_q;

    // Align sample signs with the symbol error
    always_ff @(posedge clk) begin
        if (sreset_eq) begin
            sign_dly_i <= '0;
            sign_dly_q <= '0;
        end else if (i_vld) begin
            sign_dly_i <= {sign_dly_i[DLY-2:0], i_data_i[`EQ_DATA_WIDTH-1]};
            sign_dly_q <= {sign_dly_q[DLY-2:0], i_data_q[`EQ_DATA_WIDTH-1]};
        end
    end

    // Tap 0 holds the newest sign
    always_ff @(posedge clk) begin
        if (sreset_eq) begin
            hist_i <= '0;
            hist_q <= '0;
            err_i  <= '0;
            err_q  <= '0;
        end else if (i_sym_vld) begin
            hist_i <= {hist_i[`EQ_TAP_NUM-2:0], sign_dly_i[DLY-1]};
            hist_q <= {hist_q[`EQ_TAP_NUM-2:0], sign_dly_q[DLY-1]};
            // Sign-sign product, uses the history before the shift
            err_i  <= hist_i ^ {`EQ_TAP_NUM{i_err_i}};
            err_q  <= hist_q ^ {`EQ_TAP_NUM{i_err_q}};
        end
    end

    assign o_err_i = err_i;
    assign o_err_q = err_q;

endmodule

/* logic/coef_trainer.sv */
`timescale 1ns/1ps
`include "eq_config.svh"

module coef_trainer (
    input  logic                clk,
    input  logic                sreset_eq,
    input  logic                i_preset,
    input  logic                i_train,
    input  logic                i_leak,
    input  logic                i_sym_vld,
    input  eq_pkg::tap_bits_t   i_err_i,
    input  eq_pkg::tap_bits_t   i_err_q,
    output eq_pkg::coe_vec_t    o_coe_i,
    output eq_pkg::coe_vec_t    o_coe_q
);

    localparam int CENTER = `EQ_TAP_NUM / 2;
    localparam int FULL_W = `EQ_COE_WIDTH + `EQ_COE_EXT;

    localparam logic [`EQ_COE_WIDTH-1:0] COE_MAX = {1'b0, {(`EQ_COE_WIDTH-1){1'b1}}};

    eq_pkg::coe_full_t   cnt_i [`EQ_TAP_NUM];
    eq_pkg::coe_full_t   cnt_q [`EQ_TAP_NUM];
    eq_pkg::coe_vec_t    coe_i;
    eq_pkg::coe_vec_t    coe_q;

    // One counter step, leak pulls toward zero
    function automatic eq_pkg::coe_full_t step_coe(
        input eq_pkg::coe_full_t cnt,
        input logic              leak,
        input logic              err
    );
        logic up;
        up = leak ? cnt[FULL_W-1] : ~err;
        if (up) begin
            return cnt + eq_pkg::coe_full_t'(1);
        end
        return cnt - eq_pkg::coe_full_t'(1);
    endfunction

    // Round half up, saturate at max positive
    function automatic eq_pkg::coe_t round_coe(input eq_pkg::coe_full_t cnt);
        logic [`EQ_COE_WIDTH-1:0] top;
        top = cnt[FULL_W-1:`EQ_COE_EXT];
        if (top == COE_MAX) begin
            return eq_pkg::coe_t'(top);
        end
        return eq_pkg::coe_t'(top + {{(`EQ_COE_WIDTH-1){1'b0}}, cnt[`EQ_COE_EXT-1]});
    endfunction

    // Wide training counters
    always_ff @(posedge clk) begin
        if (sreset_eq || i_preset) begin
            for (int k = 0; k < `EQ_TAP_NUM; k++) begin
                cnt_i[k] <= (k == CENTER) ? eq_pkg::COE_ONE : '0;
                cnt_q[k] <= '0;
            end
        end else if (i_train) begin
            for (int k = 0; k < `EQ_TAP_NUM; k++) begin
                cnt_i[k] <= step_coe(cnt_i[k], i_leak, i_err_i[k]);
                cnt_q[k] <= step_coe(cnt_q[k], i_leak, i_err_q[k]);
            end
        end
    end

    // Filter coefficients, refreshed once per symbol
    always_ff @(posedge clk) begin
        if (sreset_eq || i_preset) begin
            coe_i         <= '0;
            coe_i[CENTER] <= eq_pkg::COE_ONE_RND;
            coe_q         <= '0;
        end else if (i_sym_vld) begin
            for (int k = 0; k < `EQ_TAP_NUM; k++) begin
                coe_i[k] <= round_coe(cnt_i[k]);
                coe_q[k] <= round_coe(cnt_q[k]);
            end
        end
    end

    assign o_coe_i = coe_i;
    assign o_coe_q = coe_q;

endmodule

/* fir/fir_filter.sv */
`timescale 1ns/1ps
`include "eq_config.svh"

module fir_filter (
    input  logic               clk,
    input  logic               sreset_eq,
    input  eq_pkg::coe_vec_t   i_coe,
    input  eq_pkg::sample_t    i_data,
    input  logic               i_vld,
    output eq_pkg::acc_t       o_dout,
    output logic               o_vld
);

    eq_pkg::sample_t   line [`EQ_TAP_NUM];
    logic              line_vld;
    eq_pkg::acc_t      sum;
    eq_pkg::acc_t      dout;
    logic              dout_vld;

    // Tap delay line, newest sample at tap 0
    always_ff @(posedge clk) begin
        if (sreset_eq) begin
            for (int k = 0; k < `EQ_TAP_NUM; k++) begin
                line[k] <= '0;
            end
        end else if (i_vld) begin
            line[0] <= i_data;
            for (int k = 1; k < `EQ_TAP_NUM; k++) begin
                line[k] <= line[k-1];
            end
        end
    end

    // Full precision, 4 guard bits cover the tap sum
    always_comb begin
        sum = '0;
        for (int k = 0; k < `EQ_TAP_NUM; k++) begin
            sum = sum + line[k] * $signed(i_coe[k]);
        end
    end

    always_ff @(posedge clk) begin
        if (sreset_eq) begin
            line_vld <= 1'b0;
            dout_vld <= 1'b0;
        end else begin
            line_vld <= i_vld;
            dout_vld <= line_vld;
        end
    end

    // Output holds between valids
    always_ff @(posedge clk) begin
        if (sreset_eq) begin
            dout <= '0;
        end else if (line_vld) begin
            dout <= sum;
        end
    end

    assign o_dout = dout;
    assign o_vld  = dout_vld;

endmodule

/* logic/lms_equalizer.sv */
`timescale 1ns/1ps

module lms_equalizer (
    input  logic              clk,
    input  logic              sreset_eq,
    input  logic              i_preset,
    input  logic              i_teach_en,
    input  eq_pkg::period_t   i_norm_period,
    input  logic              i_sym_vld,
    input  logic              i_err_i,
    input  logic              i_err_q,
    input  eq_pkg::sample_t   i_data_i,
    input  eq_pkg::sample_t   i_data_q,
    input  logic              i_vld,
    output eq_pkg::acc_t      o_dout_ii,
    output eq_pkg::acc_t      o_dout_qq,
    output eq_pkg::acc_t      o_dout_iq,
    output eq_pkg::acc_t      o_dout_qi,
    output logic              o_vld
);

    logic                preset;
    logic                train;
    logic                leak;
    eq_pkg::tap_bits_t   tap_err_i;
    eq_pkg::tap_bits_t   tap_err_q;
    eq_pkg::coe_vec_t    coe_i;
    eq_pkg::coe_vec_t    coe_q;

    eq_control eq_control_inst (
        .clk            (clk),
        .sreset_eq      (sreset_eq),
        .i_preset       (i_preset),
        .i_teach_en     (i_teach_en),
        .i_norm_period  (i_norm_period),
        .i_sym_vld      (i_sym_vld),
        .o_preset       (preset),
        .o_train        (train),
        .o_leak         (leak)
    );

    sign_error_gen sign_error_gen_inst (
        .clk            (clk),
        .sreset_eq      (sreset_eq),
        .i_data_i       (i_data_i),
        .i_data_q       (i_data_q),
        .i_vld          (i_vld),
        .i_sym_vld      (i_sym_vld),
        .i_err_i        (i_err_i),
        .i_err_q        (i_err_q),
        .o_err_i        (tap_err_i),
        .o_err_q        (tap_err_q)
    );

    coef_trainer coef_trainer_inst (
        .clk            (clk),
        .sreset_eq      (sreset_eq),
        .i_preset       (preset),
        .i_train        (train),
        .i_leak         (leak),
        .i_sym_vld      (i_sym_vld),
        .i_err_i        (tap_err_i),
        .i_err_q        (tap_err_q),
        .o_coe_i        (coe_i),
        .o_coe_q        (coe_q)
    );

    // I set feeds II and QI, Q set feeds QQ and IQ
    fir_filter fir_ii (
        .clk            (clk),
        .sreset_eq      (sreset_eq),
        .i_coe          (coe_i),
        .i_data         (i_data_i),
        .i_vld          (i_vld),
        .o_dout         (o_dout_ii),
        .o_vld          (o_vld)
    );

    // Valids below track fir_ii
    fir_filter fir_qq (
        .clk            (clk),
        .sreset_eq      (sreset_eq),
        .i_coe          (coe_q),
        .i_data         (i_data_q),
        .i_vld          (i_vld),
        .o_dout         (o_dout_qq),
        .o_vld          ()
    );

    fir_filter fir_iq (
        .clk            (clk),
        .sreset_eq      (sreset_eq),
        .i_coe          (coe_q),
        .i_data         (i_data_i),
        .i_vld          (i_vld),
        .o_dout         (o_dout_iq),
        .o_vld          ()
    );

    fir_filter fir_qi (
        .clk            (clk),
        .sreset_eq      (sreset_eq),
        .i_coe          (coe_i),
        .i_data         (i_data_q),
        .i_vld          (i_vld),
        .o_dout         (o_dout_qi),
        .o_vld          ()
    );

endmodule

/* tests/lms_equalizer_assert.sv */
`timescale 1ns/1ps

module lms_equalizer_assert (
    input logic clk,
    input logic sreset_eq,
    input logic i_vld,
    input logic o_vld,
    input logic i_sym_vld,
    input logic i_teach_en,
    input logic i_leak
);

    int fail_count = 0;

    // Valid pipe cleared by reset
    vld_in_reset: assert property (@(posedge clk) sreset_eq |=> !o_vld)
        else begin
            fail_count++;
            $error("o_vld high after a reset cycle");
        end

    vld_latency: assert property (@(posedge clk) disable iff (sreset_eq)
        o_vld |-> $past(i_vld, 2))
        else begin
            fail_count++;
            $error("o_vld without i_vld two cycles earlier");
        end

    // Leak only replaces a training step
    leak_in_train: assert property (@(posedge clk) disable iff (sreset_eq)
        i_leak |-> i_sym_vld && $past(i_teach_en))
        else begin
            fail_count++;
            $error("leak strobe outside a training cycle");
        end

endmodule

bind lms_equalizer lms_equalizer_assert lms_equalizer_assert_inst (
    .clk        (clk),
    .sreset_eq  (sreset_eq),
    .i_vld      (i_vld),
    .o_vld      (o_vld),
    .i_sym_vld  (i_sym_vld),
    .i_teach_en (i_teach_en),
    .i_leak     (leak)
);

/* tests/lms_equalizer_tb.sv */
`timescale 1ns/1ps
`include "eq_config.svh"

module lms_equalizer_tb;

    localparam int TAPS   = `EQ_TAP_NUM;
    localparam int CENTER = TAPS / 2;
    localparam int DLY    = `EQ_SIGN_DELAY;
    // Centre tap one as a counter and after rounding
    localparam int ONE_CNT = (1 << 21) - 1;
    localparam int ONE_RND = 8191;

    logic              clk;
    logic              sreset_eq;
    logic              i_preset;
    logic              i_teach_en;
    eq_pkg::period_t   i_norm_period;
    logic              i_sym_vld;
    logic              i_err_i;
    logic              i_err_q;
    eq_pkg::sample_t   i_data_i;
    eq_pkg::sample_t   i_data_q;
    logic              i_vld;
    eq_pkg::acc_t      o_dout_ii;
    eq_pkg::acc_t      o_dout_qq;
    eq_pkg::acc_t      o_dout_iq;
    eq_pkg::acc_t      o_dout_qi;
    logic              o_vld;

    integer seed;
    int     errors;
    int     checks;

    // Model state advanced once per clock edge
    logic                         pre_m;
    logic                         teach_m;
    eq_pkg::period_t              period_m;
    eq_pkg::period_t              pcnt_m;
    logic [DLY-1:0]               sd_i_m;
    logic [DLY-1:0]               sd_q_m;
    eq_pkg::tap_bits_t            hist_i_m;
    eq_pkg::tap_bits_t            hist_q_m;
    eq_pkg::tap_bits_t            err_i_m;
    eq_pkg::tap_bits_t            err_q_m;
    int                           cnt_i_m [TAPS];
    int                           cnt_q_m [TAPS];
    eq_pkg::coe_vec_t             coe_i_m;
    eq_pkg::coe_vec_t             coe_q_m;
    eq_pkg::sample_t [TAPS-1:0]   line_i_m;
    eq_pkg::sample_t [TAPS-1:0]   line_q_m;

    longint exp_ii [$];
    longint exp_qq [$];
    longint exp_iq [$];
    longint exp_qi [$];
    logic   vld_d1;
    logic   vld_d2;

    lms_equalizer lms_equalizer_inst (
        .clk            (clk),
        .sreset_eq      (sreset_eq),
        .i_preset       (i_preset),
        .i_teach_en     (i_teach_en),
        .i_norm_period  (i_norm_period),
        .i_sym_vld      (i_sym_vld),
        .i_err_i        (i_err_i),
        .i_err_q        (i_err_q),
        .i_data_i       (i_data_i),
        .i_data_q       (i_data_q),
        .i_vld          (i_vld),
        .o_dout_ii      (o_dout_ii),
        .o_dout_qq      (o_dout_qq),
        .o_dout_iq      (o_dout_iq),
        .o_dout_qi      (o_dout_qi),
        .o_vld          (o_vld)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic longint expected_fir(
        input eq_pkg::coe_vec_t             coe,
        input eq_pkg::sample_t [TAPS-1:0]   line
    );
        longint acc;
        acc = 0;
        for (int k = 0; k < TAPS; k++) begin
            acc += longint'($signed(coe[k])) * longint'($signed(line[k]));
        end
        return acc;
    endfunction

    // Sign-sign step where leak always heads for zero
    function automatic int next_count(input int c, input logic leak, input logic err);
        if (leak) begin
            return (c < 0) ? c + 1 : c - 1;
        end
        return err ? c - 1 : c + 1;
    endfunction

    function automatic int round_count(input int c);
        int r;
        r = (c + (1 << (`EQ_COE_EXT - 1))) >>> `EQ_COE_EXT;
        return (r > 32767) ? 32767 : r;
    endfunction

    function automatic int magnitude(input int v);
        return (v < 0) ? -v : v;
    endfunction

    function automatic eq_pkg::sample_t rand_sample();
        return eq_pkg::sample_t'($random(seed));
    endfunction

    task automatic load_preset();
        for (int k = 0; k < TAPS; k++) begin
            cnt_i_m[k] = (k == CENTER) ? ONE_CNT : 0;
            cnt_q_m[k] = 0;
        end
        coe_i_m         = '0;
        coe_i_m[CENTER] = eq_pkg::coe_t'(ONE_RND);
        coe_q_m         = '0;
    endtask

    task automatic update_model(
        input logic              vld,
        input eq_pkg::sample_t   di,
        input eq_pkg::sample_t   dq,
        input logic              sym,
        input logic              ei,
        input logic              eq_bit
    );
        logic hit;
        logic train;
        logic leak;
        hit   = sym && (pcnt_m == period_m);
        train = sym && teach_m;
        leak  = hit && teach_m;
        if (pre_m) begin
            load_preset();
        end else begin
            // Coefficients take the counters from before this edge
            for (int k = 0; k < TAPS; k++) begin
                if (sym) begin
                    coe_i_m[k] = eq_pkg::coe_t'(round_count(cnt_i_m[k]));
                    coe_q_m[k] = eq_pkg::coe_t'(round_count(cnt_q_m[k]));
                end
                if (train) begin
                    cnt_i_m[k] = next_count(cnt_i_m[k], leak, err_i_m[k]);
                    cnt_q_m[k] = next_count(cnt_q_m[k], leak, err_q_m[k]);
                end
            end
        end
        if (sym) begin
            for (int k = 0; k < TAPS; k++) begin
                err_i_m[k] = hist_i_m[k] ^ ei;
                err_q_m[k] = hist_q_m[k] ^ eq_bit;
            end
            hist_i_m = {hist_i_m[TAPS-2:0], sd_i_m[DLY-1]};
            hist_q_m = {hist_q_m[TAPS-2:0], sd_q_m[DLY-1]};
        end
        if (vld) begin
            sd_i_m = {sd_i_m[DLY-2:0], di[`EQ_DATA_WIDTH-1]};
            sd_q_m = {sd_q_m[DLY-2:0], dq[`EQ_DATA_WIDTH-1]};
        end
        if (hit) begin
            pcnt_m = '0;
        end else if (sym) begin
            pcnt_m = pcnt_m + 1'b1;
        end
        pre_m    = i_preset;
        teach_m  = i_teach_en;
        period_m = i_norm_period;
        if (vld) begin
            line_i_m = {line_i_m[TAPS-2:0], di};
            line_q_m = {line_q_m[TAPS-2:0], dq};
            exp_ii.push_back(expected_fir(coe_i_m, line_i_m));
            exp_qq.push_back(expected_fir(coe_q_m, line_q_m));
            exp_iq.push_back(expected_fir(coe_q_m, line_i_m));
            exp_qi.push_back(expected_fir(coe_i_m, line_q_m));
        end
    endtask

    task automatic run_cycle(
        input logic              vld,
        input eq_pkg::sample_t   di,
        input eq_pkg::sample_t   dq,
        input logic              sym,
        input logic              ei,
        input logic              eq_bit
    );
        i_vld     = vld;
        i_data_i  = di;
        i_data_q  = dq;
        i_sym_vld = sym;
        i_err_i   = ei;
        i_err_q   = eq_bit;
        update_model(vld, di, dq, sym, ei, eq_bit);
        @(posedge clk);
        #1;
    endtask

    task automatic idle_symbols(input int n);
        repeat (n) run_cycle(1'b0, '0, '0, 1'b1, 1'b0, 1'b0);
    endtask

    task automatic wait_outputs();
        int n;
        n = 0;
        while (exp_ii.size() != 0 && n < 16) begin
            run_cycle(1'b0, '0, '0, 1'b0, 1'b0, 1'b0);
            n++;
        end
        if (exp_ii.size() != 0) begin
            errors++;
            $display("Timed out at %0t with %0d filter outputs missing", $time, exp_ii.size());
            exp_ii.delete();
            exp_qq.delete();
            exp_iq.delete();
            exp_qi.delete();
        end
    endtask

    // Flush the lines and then send a unit impulse on one rail
    task automatic send_impulse(input logic on_q);
        repeat (TAPS) run_cycle(1'b1, '0, '0, 1'b0, 1'b0, 1'b0);
        run_cycle(1'b1, on_q ? 16'sd0 : 16'sd1, on_q ? 16'sd1 : 16'sd0, 1'b0, 1'b0, 1'b0);
        repeat (TAPS - 1) run_cycle(1'b1, '0, '0, 1'b0, 1'b0, 1'b0);
        wait_outputs();
    endtask

    task automatic compare_out(input string name, input eq_pkg::acc_t got, input longint want);
        checks++;
        assert (longint'(got) == want) else begin
            errors++;
            $display("FAIL at %0t: %s output %0d, expected %0d", $time, name, got, want);
        end
    endtask

    // o_vld must follow i_vld by two cycles
    always @(negedge clk) begin
        if (sreset_eq) begin
            vld_d1 = 1'b0;
            vld_d2 = 1'b0;
        end else begin
            checks++;
            assert (o_vld === vld_d2) else begin
                errors++;
                $display("FAIL at %0t: o_vld %b, i_vld two cycles before %b", $time, o_vld, vld_d2);
            end
            vld_d2 = vld_d1;
            vld_d1 = i_vld;
            if (o_vld) begin
                if (exp_ii.size() == 0) begin
                    errors++;
                    $display("Output valid at %0t with no expected result queued", $time);
                end else begin
                    compare_out("II", o_dout_ii, exp_ii.pop_front());
                    compare_out("QQ", o_dout_qq, exp_qq.pop_front());
                    compare_out("IQ", o_dout_iq, exp_iq.pop_front());
                    compare_out("QI", o_dout_qi, exp_qi.pop_front());
                end
            end
        end
    end

    initial begin
        logic             v;
        logic             s;
        logic             e_i;
        logic             e_q;
        int               syms;
        int               n;
        eq_pkg::coe_vec_t coe_i_before;
        eq_pkg::coe_vec_t coe_q_before;
        seed          = 32'hd202_770f;
        errors        = 0;
        checks        = 0;
        sreset_eq     = 1'b1;
        i_preset      = 1'b0;
        i_teach_en    = 1'b0;
        i_norm_period = eq_pkg::period_t'(`EQ_PERIOD_DEFAULT);
        i_sym_vld     = 1'b0;
        i_err_i       = 1'b0;
        i_err_q       = 1'b0;
        i_data_i      = '0;
        i_data_q      = '0;
        i_vld         = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        sreset_eq = 1'b0;
        pre_m     = 1'b1;
        teach_m   = 1'b0;
        period_m  = eq_pkg::period_t'(`EQ_PERIOD_DEFAULT);
        pcnt_m    = '0;
        sd_i_m    = '0;
        sd_q_m    = '0;
        hist_i_m  = '0;
        hist_q_m  = '0;
        err_i_m   = '0;
        err_q_m   = '0;
        line_i_m  = '0;
        line_q_m  = '0;
        load_preset();

        send_impulse(1'b0);

        // Back to back samples
        repeat (40) run_cycle(1'b1, rand_sample(), rand_sample(), 1'b0, 1'b0, 1'b0);
        wait_outputs();

        // Gapped valids
        repeat (60) begin
            v = $random(seed);
            run_cycle(v, rand_sample(), rand_sample(), 1'b0, 1'b0, 1'b0);
        end
        wait_outputs();

        i_teach_en = 1'b1;
        syms = 0;
        while (syms < 300) begin
            v   = $random(seed);
            s   = $random(seed);
            e_i = $random(seed);
            e_q = $random(seed);
            run_cycle(v, rand_sample(), rand_sample(), s, e_i, e_q);
            if (s) begin
                syms++;
            end
        end
        i_teach_en = 1'b0;
        idle_symbols(2);
        send_impulse(1'b0);
        send_impulse(1'b1);
        repeat (30) run_cycle(1'b1, rand_sample(), rand_sample(), 1'b0, 1'b0, 1'b0);
        wait_outputs();

        // Leak on every symbol with the period counter restarted from zero
        coe_i_before = coe_i_m;
        coe_q_before = coe_q_m;
        n = 0;
        while (pcnt_m != 0 && n < 16) begin
            idle_symbols(1);
            n++;
        end
        if (pcnt_m != 0) begin
            errors++;
            $display("Period counter did not return to zero by %0t", $time);
        end
        i_norm_period = '0;
        run_cycle(1'b0, '0, '0, 1'b0, 1'b0, 1'b0);
        i_teach_en = 1'b1;
        repeat (40) run_cycle(1'b1, rand_sample(), rand_sample(), 1'b1, 1'b0, 1'b0);
        i_teach_en = 1'b0;
        idle_symbols(2);
        for (int k = 0; k < TAPS; k++) begin
            checks++;
            assert (magnitude(lms_equalizer_inst.coe_i[k]) <= magnitude(coe_i_before[k]) &&
                    magnitude(lms_equalizer_inst.coe_q[k]) <= magnitude(coe_q_before[k])) else begin
                errors++;
                $display("FAIL at %0t: tap %0d coefficient moved away from zero", $time, k);
            end
        end
        send_impulse(1'b0);
        send_impulse(1'b1);

        i_preset = 1'b1;
        idle_symbols(1);
        send_impulse(1'b0);
        i_preset = 1'b0;
        run_cycle(1'b0, '0, '0, 1'b0, 1'b0, 1'b0);

        errors += lms_equalizer_inst.lms_equalizer_assert_inst.fail_count;
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+common
common/eq_pkg.sv
logic/eq_control.sv
logic/sign_error_gen.sv
logic/coef_trainer.sv
fir/fir_filter.sv
logic/lms_equalizer.sv
tests/lms_equalizer_assert.sv
tests/lms_equalizer_tb.sv
